// ==== mdc_clock_gen.sv ====
`timescale 1ns/1ns

module mdc_clock_gen #(
	parameter int CLK_DIV = 60
) (
	input  logic clk,
	input  logic reset,
	output logic mdc,
	output logic mdc_rise,
	output logic mdc_fall
);

	// Half period in clk cycles
	localparam int HALF_DIV = CLK_DIV / 2;
	localparam int CNT_W = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_DIV - 1);

	logic [CNT_W-1:0] div_cnt;

	//////////////////////////////////////////////////////////////////////
	// Free running divider

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt  <= '0;
			mdc      <= 1'b0;
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
		end else begin
			// Strobes last one cycle only
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
			if (div_cnt == CNT_LAST) begin
				div_cnt <= '0;
				mdc     <= ~mdc;
				// Strobe rises together with the new mdc level
				mdc_rise <= ~mdc;
				mdc_fall <= mdc;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== mdio_frame_pkg.sv ====
package mdio_frame_pkg;

	//////////////////////////////////////////////////////////////////////
	// Clause 22 frame layout

	// Field widths in wire order
	localparam int ST_W    = 2;
	localparam int OP_W    = 2;
	localparam int PHYAD_W = 5;
	localparam int REGAD_W = 5;
	localparam int TA_W    = 2;
	localparam int DATA_W  = 16;

	// Bits after the preamble
	localparam int FRAME_BITS = 32;

	// Last master-driven bit of a read, counted from the first frame bit
	localparam int ADDR_END_BIT = ST_W + OP_W + PHYAD_W + REGAD_W;

	//////////////////////////////////////////////////////////////////////
	// Line codes

	localparam logic [ST_W-1:0] ST_CODE  = 2'b01;
	localparam logic [OP_W-1:0] OP_READ  = 2'b10;
	localparam logic [OP_W-1:0] OP_WRITE = 2'b01;

	// Master drives 1 then 0 on a write
	localparam logic [TA_W-1:0] TA_WRITE = 2'b10;

	// Fields MSB first, st goes out on the wire first
	typedef struct packed {
		logic [ST_W-1:0]    st;
		logic [OP_W-1:0]    op;
		logic [PHYAD_W-1:0] phyad;
		logic [REGAD_W-1:0] regad;
		logic [TA_W-1:0]    ta;
		logic [DATA_W-1:0]  data;
	} frame_fields_t;

	// Built as fields, shifted as raw bits
	typedef union packed {
		frame_fields_t           fields;
		logic [FRAME_BITS-1:0]   raw;
	} frame_u;

endpackage

// ==== mdio_frame_shifter.sv ====
`timescale 1ns/1ns

module mdio_frame_shifter (
	input  logic clk,
	input  logic reset,
	input  logic mdc_rise,
	input  logic mdc_fall,
	mdio_shift_if.shifter shift,
	output logic mdio_tx_data,
	output logic mdio_tx_en,
	input  logic mdio_rx_data
);

	// Bit positions counted from 1 at the first frame bit
	localparam logic [5:0] LAST_BIT    = 6'(mdio_frame_pkg::FRAME_BITS);
	localparam logic [5:0] RELEASE_BIT = 6'(mdio_frame_pkg::ADDR_END_BIT);
	localparam logic [5:0] TA_END_BIT  =
		6'(mdio_frame_pkg::ADDR_END_BIT + mdio_frame_pkg::TA_W);

	logic [mdio_frame_pkg::FRAME_BITS-1:0] sr;
	logic [5:0] bit_cnt;
	logic active;
	logic is_read;
	logic done_r;
	mdio_host_pkg::reg_data_t cap;

	//////////////////////////////////////////////////////////////////////
	// Line control

	always_ff @(posedge clk) begin
		if (reset) begin
			active       <= 1'b0;
			is_read      <= 1'b0;
			bit_cnt      <= '0;
			done_r       <= 1'b0;
			mdio_tx_en   <= 1'b0;
			mdio_tx_data <= 1'b0;
		end else begin
			done_r <= 1'b0;
			if (shift.load) begin
				// First frame bit goes out at the load edge
				active       <= 1'b1;
				is_read      <= (shift.frame.fields.op == mdio_frame_pkg::OP_READ);
				bit_cnt      <= 6'd1;
				mdio_tx_en   <= 1'b1;
				mdio_tx_data <= shift.frame.raw[mdio_frame_pkg::FRAME_BITS-1];
			end else if (active && mdc_fall) begin
				if (!is_read && bit_cnt == LAST_BIT) begin
					// Write finished, let go of the line
					active       <= 1'b0;
					done_r       <= 1'b1;
					mdio_tx_en   <= 1'b0;
					mdio_tx_data <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 6'd1;
					// Read turns the line around after the register address
					if (is_read && bit_cnt >= RELEASE_BIT) begin
						mdio_tx_en   <= 1'b0;
						mdio_tx_data <= 1'b0;
					end else begin
						mdio_tx_data <= sr[mdio_frame_pkg::FRAME_BITS-1];
					end
				end
			end else if (active && is_read && mdc_rise && bit_cnt == LAST_BIT) begin
				// Last data bit taken this edge
				active <= 1'b0;
				done_r <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift and capture registers

	always_ff @(posedge clk) begin
		// Head bit already on the line at load
		if (shift.load) begin
			sr <= shift.frame.raw << 1;
		end else if (active && mdc_fall) begin
			sr <= sr << 1;
		end
		// PHY data sampled mid-bit, MSB first
		if (active && is_read && mdc_rise && bit_cnt > TA_END_BIT) begin
			cap <= {cap[14:0], mdio_rx_data};
		end
	end

	assign shift.done    = done_r;
	assign shift.rd_data = cap;

endmodule

// ==== mdio_host_pkg.sv ====
package mdio_host_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host side command types

	// Register number inside one PHY
	typedef logic [4:0] reg_addr_t;

	// Station address on the shared bus
	typedef logic [4:0] phy_addr_t;

	// One management register word
	typedef logic [15:0] reg_data_t;

	//////////////////////////////////////////////////////////////////////
	// Sequencer states

	// Gap holds busy after the frame
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		PREAMBLE = 2'd1,
		FRAME    = 2'd2,
		GAP      = 2'd3
	} seq_state_t;

endpackage

// ==== mdio_master.sv ====
`timescale 1ns/1ns

module mdio_master #(
	parameter int CLK_DIV      = 60,
	parameter int PREAMBLE_LEN = 32,
	parameter int GAP_CYCLES   = 16
) (
	input  logic clk,
	input  logic reset,
	input  mdio_host_pkg::phy_addr_t phy_addr,
	input  mdio_host_pkg::reg_addr_t reg_addr,
	input  mdio_host_pkg::reg_data_t wr_data,
	input  logic reg_wr,
	input  logic reg_rd,
	output logic busy,
	output mdio_host_pkg::reg_data_t rd_data,
	output logic mdc,
	output logic mdio_tx_data,
	output logic mdio_tx_en,
	input  logic mdio_rx_data
);

	logic mdc_rise;
	logic mdc_fall;
	logic pre_en;
	logic sh_tx_data;
	logic sh_tx_en;

	// Sequencer to shifter
	mdio_shift_if shift_bus ();

	//////////////////////////////////////////////////////////////////////
	// Blocks

	mdc_clock_gen #(
		.CLK_DIV (CLK_DIV)
	) u_clock_gen (
		.clk      (clk),
		.reset    (reset),
		.mdc      (mdc),
		.mdc_rise (mdc_rise),
		.mdc_fall (mdc_fall)
	);

	mdio_sequencer #(
		.PREAMBLE_LEN (PREAMBLE_LEN),
		.GAP_CYCLES   (GAP_CYCLES)
	) u_sequencer (
		.clk      (clk),
		.reset    (reset),
		.mdc_fall (mdc_fall),
		.phy_addr (phy_addr),
		.reg_addr (reg_addr),
		.wr_data  (wr_data),
		.reg_wr   (reg_wr),
		.reg_rd   (reg_rd),
		.busy     (busy),
		.rd_data  (rd_data),
		.pre_en   (pre_en),
		.shift    (shift_bus.seq)
	);

	mdio_frame_shifter u_shifter (
		.clk          (clk),
		.reset        (reset),
		.mdc_rise     (mdc_rise),
		.mdc_fall     (mdc_fall),
		.shift        (shift_bus.shifter),
		.mdio_tx_data (sh_tx_data),
		.mdio_tx_en   (sh_tx_en),
		.mdio_rx_data (mdio_rx_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Line merge

	// Preamble is all ones, driven
	assign mdio_tx_en   = pre_en ? 1'b1 : sh_tx_en;
	assign mdio_tx_data = pre_en ? 1'b1 : sh_tx_data;

endmodule

// ==== mdio_master_assertions.sv ====
`timescale 1ns/1ns

module mdio_master_assertions (
	input logic clk,
	input logic reset,
	input logic reg_wr,
	input logic reg_rd,
	input logic mdio_tx_en,
	input mdio_host_pkg::seq_state_t state,
	input logic busy_r,
	input logic sh_active,
	input logic sh_is_read,
	input logic [5:0] sh_bit_cnt
);

	// Line released whenever the FSM is idle
	assert property (@(posedge clk) disable iff (reset)
		state == mdio_host_pkg::IDLE |-> !mdio_tx_en)
		else $error("mdio_tx_en high while the sequencer is idle");

	// Host must wait for busy to drop
	assert property (@(posedge clk) disable iff (reset)
		(reg_wr || reg_rd) |-> !busy_r)
		else $error("strobe issued during a transaction");

	// PHY owns the line for the data bits
	assert property (@(posedge clk) disable iff (reset)
		(sh_active && sh_is_read && sh_bit_cnt > 6'd16) |-> !mdio_tx_en)
		else $error("master drives the line during read data");

endmodule

bind mdio_master mdio_master_assertions u_assertions (
	.clk        (clk),
	.reset      (reset),
	.reg_wr     (reg_wr),
	.reg_rd     (reg_rd),
	.mdio_tx_en (mdio_tx_en),
	.state      (u_sequencer.state),
	.busy_r     (u_sequencer.busy_r),
	.sh_active  (u_shifter.active),
	.sh_is_read (u_shifter.is_read),
	.sh_bit_cnt (u_shifter.bit_cnt)
);

// ==== mdio_phy_model.sv ====
`timescale 1ns/1ns

module mdio_phy_model #(
	parameter mdio_host_pkg::phy_addr_t PHY_ADDR = 5'h03
) (
	input  logic mdc,
	input  logic mdio_tx_en,
	input  logic mdio_tx_data,
	output logic mdio_rx_data
);

	// Register file, power-up word built from the full address
	mdio_host_pkg::reg_data_t regs [32];

	// Last decoded frame
	logic [mdio_frame_pkg::OP_W-1:0] last_op = '0;
	mdio_host_pkg::reg_addr_t last_reg = '0;
	int last_pre = 0;

	// Frame tracking
	logic in_frame = 1'b0;
	logic [5:0] pos = '0;
	logic [mdio_frame_pkg::FRAME_BITS-1:0] sr = '0;
	int pre_run = 0;
	logic [mdio_frame_pkg::OP_W-1:0] cur_op = '0;
	mdio_host_pkg::phy_addr_t cur_phy = '0;
	mdio_host_pkg::reg_addr_t cur_reg = '0;

	// Read drive
	logic phy_oe = 1'b0;
	logic phy_out = 1'b1;
	mdio_host_pkg::reg_data_t rd_sh = '0;

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = {5'(i), 3'b110, 5'(i), 3'b001};
		end
	end

	// Pull-up when nobody drives
	assign mdio_rx_data = mdio_tx_en ? mdio_tx_data : (phy_oe ? phy_out : 1'b1);

	//////////////////////////////////////////////////////////////////////
	// Frame decode on MDC rise

	always @(posedge mdc) begin
		mdio_frame_pkg::frame_u fr;
		logic [5:0] pos_n;
		pos_n = pos + 6'd1;
		fr.raw = {sr[mdio_frame_pkg::FRAME_BITS-2:0], mdio_rx_data};
		if (!in_frame) begin
			// Only driven ones count as preamble
			if (mdio_tx_en && mdio_rx_data) begin
				pre_run <= pre_run + 1;
			end else if (mdio_tx_en) begin
				// First start bit
				in_frame <= 1'b1;
				pos      <= 6'd1;
				sr       <= fr.raw;
				last_pre <= pre_run;
				pre_run  <= 0;
			end
		end else begin
			pos <= pos_n;
			sr  <= fr.raw;
			// Header complete, low 14 bits hold op, phy, reg
			if (pos_n == 6'd14) begin
				cur_op  <= fr.raw[11:10];
				cur_phy <= fr.raw[9:5];
				cur_reg <= fr.raw[4:0];
			end
			if (pos_n == 6'd32) begin
				in_frame <= 1'b0;
				last_op  <= fr.fields.op;
				last_reg <= fr.fields.regad;
				if (fr.fields.op == mdio_frame_pkg::OP_WRITE && fr.fields.phyad == PHY_ADDR) begin
					regs[fr.fields.regad] <= fr.fields.data;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read answer on MDC fall

	always @(negedge mdc) begin
		if (in_frame && cur_op == mdio_frame_pkg::OP_READ && cur_phy == PHY_ADDR
			&& pos >= 6'd15) begin
			phy_oe <= 1'b1;
			if (pos == 6'd15) begin
				// Second turnaround bit is a driven zero
				phy_out <= 1'b0;
				rd_sh   <= regs[cur_reg];
			end else begin
				phy_out <= rd_sh[15];
				rd_sh   <= {rd_sh[14:0], 1'b0};
			end
		end else begin
			phy_oe <= 1'b0;
		end
	end

endmodule

// ==== mdio_sequencer.sv ====
`timescale 1ns/1ns

module mdio_sequencer #(
	parameter int PREAMBLE_LEN = 32,
	parameter int GAP_CYCLES   = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic mdc_fall,
	input  mdio_host_pkg::phy_addr_t phy_addr,
	input  mdio_host_pkg::reg_addr_t reg_addr,
	input  mdio_host_pkg::reg_data_t wr_data,
	input  logic reg_wr,
	input  logic reg_rd,
	output logic busy,
	output mdio_host_pkg::reg_data_t rd_data,
	output logic pre_en,
	mdio_shift_if.seq shift
);

	// One counter serves preamble bits and gap cycles
	localparam int CNT_MAX = (PREAMBLE_LEN > GAP_CYCLES) ? PREAMBLE_LEN : GAP_CYCLES;
	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(PREAMBLE_LEN);
	localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(GAP_CYCLES - 1);

	mdio_host_pkg::seq_state_t state;
	logic [CNT_W-1:0] cnt;
	logic busy_r;
	logic cmd_go;
	mdio_frame_pkg::frame_u frame_q;

	// Commands only taken while idle, read has priority
	assign cmd_go = (state == mdio_host_pkg::IDLE) && (reg_rd || reg_wr);

	// High from the strobe cycle onward
	assign busy = busy_r | reg_wr | reg_rd;

	// Fall after the last preamble one starts the frame
	assign shift.load = (state == mdio_host_pkg::PREAMBLE) && mdc_fall && (cnt == PRE_LAST);
	assign shift.frame = frame_q;

	//////////////////////////////////////////////////////////////////////
	// Command latch

	always_ff @(posedge clk) begin
		if (cmd_go) begin
			frame_q.fields.st    <= mdio_frame_pkg::ST_CODE;
			frame_q.fields.op    <= reg_rd ? mdio_frame_pkg::OP_READ : mdio_frame_pkg::OP_WRITE;
			frame_q.fields.phyad <= phy_addr;
			frame_q.fields.regad <= reg_addr;
			// Read turnaround and data slots belong to the PHY
			frame_q.fields.ta    <= reg_rd ? '1 : mdio_frame_pkg::TA_WRITE;
			frame_q.fields.data  <= reg_rd ? '1 : wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transaction FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= mdio_host_pkg::IDLE;
			cnt     <= '0;
			busy_r  <= 1'b0;
			pre_en  <= 1'b0;
			rd_data <= '0;
		end else begin
			case (state)
				mdio_host_pkg::IDLE: begin
					if (cmd_go) begin
						busy_r <= 1'b1;
						cnt    <= '0;
						state  <= mdio_host_pkg::PREAMBLE;
					end
				end

				// One preamble bit per MDC fall
				mdio_host_pkg::PREAMBLE: begin
					if (mdc_fall) begin
						if (shift.load) begin
							// Shifter owns the line from here
							pre_en <= 1'b0;
							state  <= mdio_host_pkg::FRAME;
						end else begin
							pre_en <= 1'b1;
							cnt    <= cnt + 1'b1;
						end
					end
				end

				// Wait for the shifter
				mdio_host_pkg::FRAME: begin
					if (shift.done) begin
						cnt   <= '0;
						state <= mdio_host_pkg::GAP;
						if (frame_q.fields.op == mdio_frame_pkg::OP_READ) begin
							rd_data <= shift.rd_data;
						end
					end
				end

				// Idle time between frames, in clk cycles
				mdio_host_pkg::GAP: begin
					if (cnt == GAP_LAST) begin
						busy_r <= 1'b0;
						state  <= mdio_host_pkg::IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				default: begin
					state <= mdio_host_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== mdio_shift_if.sv ====
`timescale 1ns/1ns

interface mdio_shift_if;

	// Single cycle, aligned with the MDC fall that drives frame bit 31
	logic load;

	// Whole frame, sampled only at load
	mdio_frame_pkg::frame_u frame;

	// Single cycle, end of the frame
	logic done;

	// Captured read word, good while done is high
	mdio_host_pkg::reg_data_t rd_data;

	// Control side
	modport seq (
		output load,
		output frame,
		input  done,
		input  rd_data
	);

	// Datapath side
	modport shifter (
		input  load,
		input  frame,
		output done,
		output rd_data
	);

endinterface

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mdio_master -f verilog.f -o sim_mdio \
	&& ./obj_dir/sim_mdio | tee /dev/stderr | grep -q "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb_mdio_master.sv ====
`timescale 1ns/1ns

module tb_mdio_master;

	localparam int CLK_DIV      = 8;
	localparam int PREAMBLE_LEN = 32;
	localparam int GAP_CYCLES   = 16;
	localparam mdio_host_pkg::phy_addr_t PHY_ADDR = 5'h03;

	logic clk;
	logic reset;
	mdio_host_pkg::phy_addr_t phy_addr;
	mdio_host_pkg::reg_addr_t reg_addr;
	mdio_host_pkg::reg_data_t wr_data;
	logic reg_wr;
	logic reg_rd;
	logic busy;
	mdio_host_pkg::reg_data_t rd_data;
	logic mdc;
	logic mdio_tx_data;
	logic mdio_tx_en;
	logic mdio_rx_data;

	int seed;

	// Expected PHY 3 register contents
	mdio_host_pkg::reg_data_t ref_regs [32];

	mdio_master #(
		.CLK_DIV      (CLK_DIV),
		.PREAMBLE_LEN (PREAMBLE_LEN),
		.GAP_CYCLES   (GAP_CYCLES)
	) DUT (
		.clk          (clk),
		.reset        (reset),
		.phy_addr     (phy_addr),
		.reg_addr     (reg_addr),
		.wr_data      (wr_data),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.busy         (busy),
		.rd_data      (rd_data),
		.mdc          (mdc),
		.mdio_tx_data (mdio_tx_data),
		.mdio_tx_en   (mdio_tx_en),
		.mdio_rx_data (mdio_rx_data)
	);

	mdio_phy_model #(
		.PHY_ADDR (PHY_ADDR)
	) u_phy (
		.mdc          (mdc),
		.mdio_tx_en   (mdio_tx_en),
		.mdio_tx_data (mdio_tx_data),
		.mdio_rx_data (mdio_rx_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	// PHY register contents out of reset
	function automatic mdio_host_pkg::reg_data_t power_up_value(input mdio_host_pkg::reg_addr_t a);
		return {a, 3'b110, a, 3'b001};
	endfunction

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_data(input string name, input mdio_host_pkg::reg_data_t exp,
		input mdio_host_pkg::reg_data_t act);
		if (exp !== act) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_addr(input string name, input mdio_host_pkg::reg_addr_t exp,
		input mdio_host_pkg::reg_addr_t act);
		if (exp !== act) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_op(input string name, input logic [mdio_frame_pkg::OP_W-1:0] exp,
		input logic [mdio_frame_pkg::OP_W-1:0] act);
		if (exp !== act) begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("error %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	// Nothing may move before the first command
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (mdio_tx_en !== 1'b0 || busy !== 1'b0) begin
				$display("mdio_tx_en or busy went high before any command");
				stop_run();
			end
		end
	endtask

	// Clk cycles between two MDC rising edges
	task automatic measure_mdc_period(output int cycles);
		int n;
		logic prev;
		n = 0;
		prev = mdc;
		@(negedge clk);
		while (!(mdc && !prev)) begin
			if (n == 100) begin
				$display("timeout: mdc never rose");
				stop_run();
			end
			prev = mdc;
			n++;
			@(negedge clk);
		end
		prev = mdc;
		cycles = 1;
		@(negedge clk);
		while (!(mdc && !prev)) begin
			if (cycles == 100) begin
				$display("timeout: mdc did not rise again");
				stop_run();
			end
			prev = mdc;
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			if (n == 2000) begin
				$display("timeout: busy stayed high for 2000 cycles");
				stop_run();
			end
			n++;
			@(negedge clk);
		end
	endtask

	// One-cycle strobe, then wait for the end of the transaction
	task automatic run_command(input logic rd, input mdio_host_pkg::phy_addr_t p,
		input mdio_host_pkg::reg_addr_t a, input mdio_host_pkg::reg_data_t d);
		@(posedge clk);
		phy_addr <= p;
		reg_addr <= a;
		wr_data  <= d;
		reg_rd   <= rd;
		reg_wr   <= !rd;
		@(posedge clk);
		reg_rd <= 1'b0;
		reg_wr <= 1'b0;
		wait_not_busy();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int period;
		logic [31:0] rnd;
		mdio_host_pkg::reg_addr_t a;
		mdio_host_pkg::reg_data_t d;
		mdio_host_pkg::phy_addr_t p;
		seed     = 16;
		reset    = 1'b1;
		reg_wr   = 1'b0;
		reg_rd   = 1'b0;
		phy_addr = '0;
		reg_addr = '0;
		wr_data  = '0;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = power_up_value(5'(i));
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Idle line and MDC rate
		check_quiet(40);
		measure_mdc_period(period);
		compare_count("mdc period", CLK_DIV, period);

		// Random writes to PHY 3
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			a = rnd[4:0];
			d = rnd[31:16];
			run_command(1'b0, PHY_ADDR, a, d);
			ref_regs[a] = d;
			compare_data($sformatf("write %0d register", i), d, u_phy.regs[a]);
			compare_op($sformatf("write %0d opcode", i), mdio_frame_pkg::OP_WRITE, u_phy.last_op);
			compare_addr($sformatf("write %0d address", i), a, u_phy.last_reg);
			compare_count($sformatf("write %0d preamble", i), PREAMBLE_LEN, u_phy.last_pre);
		end

		// Random reads from PHY 3
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			a = rnd[4:0];
			run_command(1'b1, PHY_ADDR, a, rnd[31:16]);
			compare_data($sformatf("read %0d data", i), ref_regs[a], rd_data);
			compare_op($sformatf("read %0d opcode", i), mdio_frame_pkg::OP_READ, u_phy.last_op);
			compare_addr($sformatf("read %0d address", i), a, u_phy.last_reg);
			compare_count($sformatf("read %0d preamble", i), PREAMBLE_LEN, u_phy.last_pre);
		end

		// Absent PHY, line stays pulled up
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			p = rnd[4:0];
			if (p == PHY_ADDR) begin
				p = 5'h04;
			end
			run_command(1'b1, p, rnd[9:5], '0);
			compare_data($sformatf("absent phy read %0d", i), 16'hFFFF, rd_data);
			compare_count($sformatf("absent phy preamble %0d", i), PREAMBLE_LEN, u_phy.last_pre);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== verilog.f ====
mdio_frame_pkg.sv
mdio_host_pkg.sv
mdio_shift_if.sv
mdc_clock_gen.sv
mdio_frame_shifter.sv
mdio_sequencer.sv
mdio_master.sv
mdio_phy_model.sv
mdio_master_assertions.sv
tb_mdio_master.sv
